/* sim.f */
common/phase_bus_pkg.sv
hw/command_capture.sv
phase_bus/bus_sequencer.sv
hw/response_buffer.sv
hw/phase_bus_top.sv
sim/phase_bus_checker.sv
sim/phase_bus_tb.sv

/* sim/phase_bus_tb.sv */
module phase_bus_tb;

    localparam int NUM_RANDOM    = 40;
    localparam int NUM_COMMANDS  = NUM_RANDOM + 10;  // Random mix, directed runs, spare
    localparam int LONGEST_RUN   = 6 * (2 * phase_bus_pkg::SETTLE_CYCLES + 3) + 20;  // adc4
    localparam int WATCHDOG_TIME = NUM_COMMANDS * LONGEST_RUN * 20 * 2;

    logic                  clock = 1'b0;
    logic                  reset;
    logic                  start;
    phase_bus_pkg::cmd_t   command;
    phase_bus_pkg::byte_t  param_data [phase_bus_pkg::NUM_BOARDS];
    phase_bus_pkg::byte_t  data_in = '0;      // Driven by the card model
    logic                  busy;
    logic                  done;
    phase_bus_pkg::byte_t  response_bytes [phase_bus_pkg::NUM_BOARDS];
    phase_bus_pkg::count_t response_count;
    phase_bus_pkg::board_t board_sel;
    phase_bus_pkg::port_t  port_addr;
    logic                  rd_n;
    logic                  wr_n;
    phase_bus_pkg::byte_t  data_out;
    logic                  data_dir;

    // Card model contents
    phase_bus_pkg::byte_t  lamp [phase_bus_pkg::NUM_BOARDS];
    phase_bus_pkg::byte_t  adc_base [phase_bus_pkg::NUM_BOARDS];
    phase_bus_pkg::byte_t  mux_channel = '0;  // Last broadcast to the mux port
    logic                  wr_n_q = 1'b1;
    logic [14:0]           write_log [$];     // {board, port, data} per write strobe

    // Stimulus and reference model
    logic [31:0]           rng = 32'hc1fb;
    phase_bus_pkg::cmd_t   cur_cmd;
    phase_bus_pkg::byte_t  cur_params [phase_bus_pkg::NUM_BOARDS];
    phase_bus_pkg::byte_t  expected_bytes [phase_bus_pkg::NUM_BOARDS];  // Survives write4
    int                    errors = 0;
    int                    test_errors = 0;
    int                    tests_passed = 0;
    int                    tests_failed = 0;
    int                    done_pulses = 0;
    int                    accepted_starts = 0;
    int                    protocol_failures;  // Failed assertions in the bound checker

    assign protocol_failures =
        phase_bus_top_inst.bus_sequencer_inst.phase_bus_checker_inst.failures;

    always #10 clock = ~clock;

    phase_bus_top phase_bus_top_inst (
        .clock          (clock),
        .reset          (reset),
        .start          (start),
        .command        (command),
        .param_data     (param_data),
        .busy           (busy),
        .done           (done),
        .response_bytes (response_bytes),
        .response_count (response_count),
        .board_sel      (board_sel),
        .port_addr      (port_addr),
        .rd_n           (rd_n),
        .wr_n           (wr_n),
        .data_out       (data_out),
        .data_in        (data_in),
        .data_dir       (data_dir)
    );

    // Four lamp switch cards on the shared bus
    always @(posedge clock) begin
        wr_n_q <= wr_n;
        if (!rd_n && board_sel < phase_bus_pkg::NUM_BOARDS) begin
            if (port_addr == phase_bus_pkg::PORT_LAMP) begin
                data_in <= lamp[board_sel[1:0]];
            end else if (port_addr == phase_bus_pkg::PORT_ADC) begin
                data_in <= adc_base[board_sel[1:0]] ^ mux_channel;  // Channel skews the result
            end else begin
                data_in <= '0;
            end
        end else begin
            data_in <= '0;  // Nobody talking
        end
        if (wr_n && !wr_n_q) begin  // Write lands on the rising strobe
            write_log.push_back({board_sel, port_addr, data_out});
            if (board_sel == phase_bus_pkg::BOARD_ALL && port_addr == phase_bus_pkg::PORT_MUX) begin
                mux_channel <= data_out;
            end
        end
    end

    always @(posedge clock) begin
        if (reset) begin
            done_pulses <= 0;
        end else if (done) begin
            done_pulses <= done_pulses + 1;
        end
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Run timed out, the DUT never finished all commands");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
        errors++;
        test_errors++;
    endtask

    task automatic end_test(input string name);
        if (test_errors == 0) begin
            $display("test %s passed", name);
            tests_passed++;
        end else begin
            $display("test %s failed, %0d wrong values", name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    // New command, parameters and card contents
    task automatic randomize_run();
        rng = xorshift(rng);
        cur_cmd = phase_bus_pkg::cmd_t'(rng % 3);
        for (int i = 0; i < phase_bus_pkg::NUM_BOARDS; i++) begin
            rng = xorshift(rng);
            cur_params[i] = rng[7:0];
            lamp[i]       = rng[15:8];
            adc_base[i]   = rng[23:16];
        end
    endtask

    task automatic issue_command();
        @(posedge clock);
        start   <= 1'b1;
        command <= cur_cmd;
        for (int i = 0; i < phase_bus_pkg::NUM_BOARDS; i++) begin
            param_data[i] <= cur_params[i];
        end
        @(posedge clock);
        start <= 1'b0;
        for (int i = 0; i < phase_bus_pkg::NUM_BOARDS; i++) begin
            param_data[i] <= ~cur_params[i];  // Host moves on while the DUT holds its copy
        end
        accepted_starts++;
    endtask

    task automatic wait_done();
        do @(posedge clock); while (!done);
    endtask

    task automatic check_response(input string name);
        int                    hits;
        int                    exp_count;
        logic [14:0]           entry;
        phase_bus_pkg::byte_t  channel;
        channel = {5'b00000, cur_params[0][2:0]};
        case (cur_cmd)
            phase_bus_pkg::CMD_WRITE4: begin
                exp_count = 0;
                if (write_log.size() != 4) begin
                    report_mismatch({name, " writes"}, 4, write_log.size());
                end
                for (int i = 0; i < phase_bus_pkg::NUM_BOARDS; i++) begin
                    hits  = 0;
                    entry = {phase_bus_pkg::board_t'(i), phase_bus_pkg::PORT_LAMP, cur_params[i]};
                    foreach (write_log[k]) begin
                        if (write_log[k] == entry) hits++;
                    end
                    if (hits != 1) report_mismatch({name, " card write"}, 1, hits);
                end
            end
            phase_bus_pkg::CMD_READ4: begin
                exp_count = 4;
                if (write_log.size() != 0) begin
                    report_mismatch({name, " writes"}, 0, write_log.size());
                end
                for (int i = 0; i < phase_bus_pkg::NUM_BOARDS; i++) begin
                    expected_bytes[i] = lamp[i];
                end
            end
            default: begin  // Mux and convert writes come before the adc4 reads
                exp_count = 4;
                entry = {phase_bus_pkg::BOARD_ALL, phase_bus_pkg::PORT_MUX, channel};
                if (write_log.size() != 2) begin
                    report_mismatch({name, " writes"}, 2, write_log.size());
                end
                foreach (write_log[k]) begin
                    if (write_log[k] != entry) begin
                        report_mismatch({name, " mux write"}, entry, write_log[k]);
                    end
                end
                for (int i = 0; i < phase_bus_pkg::NUM_BOARDS; i++) begin
                    expected_bytes[i] = adc_base[i] ^ channel;
                end
            end
        endcase
        if (response_count != exp_count) begin
            report_mismatch({name, " count"}, exp_count, response_count);
        end
        for (int i = 0; i < phase_bus_pkg::NUM_BOARDS; i++) begin
            if (response_bytes[i] !== expected_bytes[i]) begin
                report_mismatch($sformatf("%s byte %0d", name, i),
                                expected_bytes[i], response_bytes[i]);
            end
        end
    endtask

    task automatic run_and_check(input string name);
        write_log.delete();
        issue_command();
        wait_done();
        check_response(name);
    endtask

    initial begin
        reset   <= 1'b1;
        start   <= 1'b0;
        command <= phase_bus_pkg::CMD_WRITE4;
        for (int i = 0; i < phase_bus_pkg::NUM_BOARDS; i++) begin
            param_data[i]     <= '0;
            expected_bytes[i] = '0;  // Response is cleared by reset
        end
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);

        if (busy !== 1'b0) report_mismatch("reset busy", 0, busy);
        if (done !== 1'b0) report_mismatch("reset done", 0, done);
        if (rd_n !== 1'b1) report_mismatch("reset rd_n", 1, rd_n);
        if (wr_n !== 1'b1) report_mismatch("reset wr_n", 1, wr_n);
        if (data_dir !== 1'b0) report_mismatch("reset data_dir", 0, data_dir);
        if (board_sel !== phase_bus_pkg::BOARD_NONE) begin
            report_mismatch("reset board_sel", phase_bus_pkg::BOARD_NONE, board_sel);
        end
        end_test("reset_state");

        randomize_run();
        cur_cmd = phase_bus_pkg::CMD_WRITE4;
        run_and_check("write4");
        end_test("write4");
        randomize_run();
        cur_cmd = phase_bus_pkg::CMD_READ4;
        run_and_check("read4");
        end_test("read4");
        randomize_run();
        cur_cmd = phase_bus_pkg::CMD_ADC4;
        run_and_check("adc4");
        end_test("adc4");

        // Second start lands mid run and must vanish
        randomize_run();
        cur_cmd = phase_bus_pkg::CMD_READ4;
        write_log.delete();
        issue_command();
        repeat (5) @(posedge clock);
        if (busy !== 1'b1) report_mismatch("start_while_busy busy", 1, busy);
        start   <= 1'b1;
        command <= phase_bus_pkg::CMD_ADC4;
        @(posedge clock);
        start <= 1'b0;
        wait_done();
        check_response("start_while_busy");
        repeat (LONGEST_RUN) @(posedge clock);  // Room for a stray run to show up
        if (done_pulses != accepted_starts) begin
            report_mismatch("start_while_busy done pulses", accepted_starts, done_pulses);
        end
        if (busy !== 1'b0) report_mismatch("start_while_busy idle", 0, busy);
        end_test("start_while_busy");

        for (int n = 0; n < NUM_RANDOM; n++) begin
            randomize_run();
            run_and_check($sformatf("random %0d", n));
        end
        end_test("random_mix");

        if (protocol_failures != 0) begin
            $display("Bus protocol assertions failed %0d times", protocol_failures);
            errors += protocol_failures;
        end

        $display("Tests passed %0d, failed %0d, wrong values %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* sim/phase_bus_checker.sv */
module phase_bus_checker (
    input logic clock,
    input logic reset,
    input logic rd_n,
    input logic wr_n,
    input logic data_dir,
    input logic finish
);

    int failures = 0;  // Count of failed assertions

    // Only one strobe on the bus at a time
    strobe_exclusive: assert property (@(posedge clock) disable iff (reset) rd_n || wr_n)
        else begin
            $error("rd_n and wr_n low in the same cycle");
            failures++;
        end

    // Controller owns the bus during a write
    write_drives_bus: assert property (@(posedge clock) disable iff (reset) !wr_n |-> data_dir)
        else begin
            $error("wr_n low while data_dir is low");
            failures++;
        end

    // Cards own the bus during a read
    read_releases_bus: assert property (@(posedge clock) disable iff (reset) !rd_n |-> !data_dir)
        else begin
            $error("rd_n low while data_dir is high");
            failures++;
        end

    finish_single_cycle: assert property (@(posedge clock) disable iff (reset) finish |=> !finish)
        else begin
            $error("finish held for more than one cycle");
            failures++;
        end

endmodule

// Watches the sequencer from the inside
bind bus_sequencer phase_bus_checker phase_bus_checker_inst (
    .clock    (clock),
    .reset    (reset),
    .rd_n     (rd_n),
    .wr_n     (wr_n),
    .data_dir (data_dir),
    .finish   (finish)
);

/* hw/phase_bus_top.sv */
module phase_bus_top (
    input  logic                   clock,
    input  logic                   reset,

    // Host command
    input  logic                   start,
    input  phase_bus_pkg::cmd_t    command,
    input  phase_bus_pkg::byte_t   param_data [phase_bus_pkg::NUM_BOARDS],
    output logic                   busy,

    // Host response
    output logic                   done,
    output phase_bus_pkg::byte_t   response_bytes [phase_bus_pkg::NUM_BOARDS],
    output phase_bus_pkg::count_t  response_count,

    // Phase bus to the lamp switch cards
    output phase_bus_pkg::board_t  board_sel,
    output phase_bus_pkg::port_t   port_addr,
    output logic                   rd_n,
    output logic                   wr_n,
    output phase_bus_pkg::byte_t   data_out,
    input  phase_bus_pkg::byte_t   data_in,
    output logic                   data_dir
);

    // Capture to sequencer
    logic                  go;
    phase_bus_pkg::cmd_t   cmd;
    phase_bus_pkg::byte_t  params [phase_bus_pkg::NUM_BOARDS];

    // Sequencer to capture and buffer
    logic                  finish;
    logic                  sample;
    phase_bus_pkg::slot_t  sample_slot;

    command_capture command_capture_inst (
        .clock      (clock),
        .reset      (reset),
        .start      (start),
        .command    (command),
        .param_data (param_data),
        .busy       (busy),
        .go         (go),
        .cmd        (cmd),
        .params     (params),
        .finish     (finish)
    );

    bus_sequencer bus_sequencer_inst (
        .clock       (clock),
        .reset       (reset),
        .go          (go),
        .cmd         (cmd),
        .params      (params),
        .board_sel   (board_sel),
        .port_addr   (port_addr),
        .rd_n        (rd_n),
        .wr_n        (wr_n),
        .data_dir    (data_dir),
        .data_out    (data_out),
        .sample      (sample),
        .sample_slot (sample_slot),
        .finish      (finish)
    );

    // Takes card data directly, the sequencer only says when and where
    response_buffer response_buffer_inst (
        .clock          (clock),
        .reset          (reset),
        .go             (go),
        .sample         (sample),
        .sample_slot    (sample_slot),
        .finish         (finish),
        .data_in        (data_in),
        .response_bytes (response_bytes),
        .response_count (response_count),
        .done           (done)
    );

endmodule

/* hw/response_buffer.sv */
module response_buffer (
    input  logic                   clock,
    input  logic                   reset,

    // Control from capture and sequencer
    input  logic                   go,
    input  logic                   sample,
    input  phase_bus_pkg::slot_t   sample_slot,
    input  logic                   finish,

    // Card data straight off the bus
    input  phase_bus_pkg::byte_t   data_in,

    // Host side
    output phase_bus_pkg::byte_t   response_bytes [phase_bus_pkg::NUM_BOARDS],
    output phase_bus_pkg::count_t  response_count,
    output logic                   done
);

    phase_bus_pkg::byte_t  hold [phase_bus_pkg::NUM_BOARDS];  // Bytes of the run in progress
    phase_bus_pkg::count_t sample_count;                       // Reads since go

    // Holding slots
    always_ff @(posedge clock) begin
        if (sample) begin
            hold[sample_slot] <= data_in;
        end
    end

    // Count, outputs and done
    always_ff @(posedge clock) begin
        if (reset) begin
            sample_count   <= '0;
            response_count <= '0;
            done           <= 1'b0;
            for (int i = 0; i < phase_bus_pkg::NUM_BOARDS; i++) begin
                response_bytes[i] <= '0;
            end
        end else begin
            done <= finish;  // Outputs and done move together

            if (go) begin
                sample_count <= '0;
            end else if (sample) begin
                sample_count <= sample_count + 1'b1;
            end

            if (finish) begin
                response_count <= sample_count;
                // A write only run has nothing new, old bytes stay
                if (sample_count != '0) begin
                    response_bytes <= hold;
                end
            end
        end
    end

endmodule

/* phase_bus/bus_sequencer.sv */
module bus_sequencer (
    input  logic                   clock,
    input  logic                   reset,

    // From command capture
    input  logic                   go,
    input  phase_bus_pkg::cmd_t    cmd,
    input  phase_bus_pkg::byte_t   params [phase_bus_pkg::NUM_BOARDS],

    // Phase bus
    output phase_bus_pkg::board_t  board_sel,
    output phase_bus_pkg::port_t   port_addr,
    output logic                   rd_n,
    output logic                   wr_n,
    output logic                   data_dir,   // 1 while we drive the bus
    output phase_bus_pkg::byte_t   data_out,

    // To the response buffer and back to capture
    output logic                   sample,
    output phase_bus_pkg::slot_t   sample_slot,
    output logic                   finish
);

    phase_bus_pkg::seq_state_t state;
    phase_bus_pkg::wait_t      wait_count;  // Shared by settle, strobe and release
    phase_bus_pkg::slot_t      board;       // Board pointer
    logic [1:0]                step;        // adc4 pass: 0 mux, 1 convert, 2 reads

    // Decode of the current access
    logic                      broadcast;
    logic                      is_write;
    logic                      last_access;
    logic                      settle_end;
    logic                      strobe_end;
    phase_bus_pkg::board_t     access_board;
    phase_bus_pkg::port_t      access_port;
    phase_bus_pkg::byte_t      access_data;

    assign settle_end = (wait_count == phase_bus_pkg::wait_t'(phase_bus_pkg::SETTLE_CYCLES - 1));
    assign strobe_end = (wait_count == phase_bus_pkg::wait_t'(phase_bus_pkg::STROBE_CYCLES - 1));

    always_comb begin
        // The first two adc4 passes go to every card at once
        broadcast = (cmd == phase_bus_pkg::CMD_ADC4) && (step != 2'd2);
        is_write  = (cmd == phase_bus_pkg::CMD_WRITE4) || broadcast;

        // Done after the fourth board, broadcasts never end a run
        last_access = !broadcast && (board == phase_bus_pkg::slot_t'(phase_bus_pkg::NUM_BOARDS - 1));

        if (broadcast) begin
            access_board = phase_bus_pkg::BOARD_ALL;
        end else begin
            access_board = phase_bus_pkg::board_t'({2'b00, board});  // Board i on code i
        end

        if (cmd == phase_bus_pkg::CMD_ADC4) begin
            access_port = broadcast ? phase_bus_pkg::PORT_MUX : phase_bus_pkg::PORT_ADC;
        end else begin
            access_port = phase_bus_pkg::PORT_LAMP;
        end

        // Mux channel sits in the low bits of the first parameter
        if (broadcast) begin
            access_data = {5'b00000, params[0][2:0]};
        end else begin
            access_data = params[board];
        end
    end

    // Main FSM and bus control
    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= phase_bus_pkg::SEQ_IDLE;
            wait_count <= '0;
            board      <= '0;
            step       <= 2'd0;
            board_sel  <= phase_bus_pkg::BOARD_NONE;
            port_addr  <= phase_bus_pkg::PORT_LAMP;
            rd_n       <= 1'b1;
            wr_n       <= 1'b1;
            data_dir   <= 1'b0;
        end else begin
            case (state)
                phase_bus_pkg::SEQ_IDLE: begin
                    if (go) begin
                        board <= '0;
                        step  <= 2'd0;  // Ignored outside adc4
                        state <= phase_bus_pkg::SEQ_ADDRESS;
                    end
                end

                phase_bus_pkg::SEQ_ADDRESS: begin
                    board_sel  <= access_board;
                    port_addr  <= access_port;
                    data_dir   <= is_write;  // Turn the bus before the strobe
                    wait_count <= '0;
                    state      <= phase_bus_pkg::SEQ_SETTLE;
                end

                phase_bus_pkg::SEQ_SETTLE: begin
                    if (settle_end) begin
                        wait_count <= '0;
                        rd_n       <= is_write;   // Low for a read
                        wr_n       <= !is_write;  // Low for a write
                        state      <= phase_bus_pkg::SEQ_STROBE;
                    end else begin
                        wait_count <= wait_count + 1'b1;
                    end
                end

                phase_bus_pkg::SEQ_STROBE: begin
                    if (strobe_end) begin
                        wait_count <= '0;
                        rd_n       <= 1'b1;
                        wr_n       <= 1'b1;  // Rising wr_n latches the card
                        state      <= phase_bus_pkg::SEQ_RELEASE;
                    end else begin
                        wait_count <= wait_count + 1'b1;
                    end
                end

                phase_bus_pkg::SEQ_RELEASE: begin
                    // Address and data held so the card sees clean hold time
                    if (settle_end) begin
                        wait_count <= '0;
                        board_sel  <= phase_bus_pkg::BOARD_NONE;
                        data_dir   <= 1'b0;
                        if (last_access) begin
                            state <= phase_bus_pkg::SEQ_FINISH;
                        end else begin
                            state <= phase_bus_pkg::SEQ_NEXT;
                        end
                    end else begin
                        wait_count <= wait_count + 1'b1;
                    end
                end

                phase_bus_pkg::SEQ_NEXT: begin
                    if (broadcast) begin
                        step <= step + 1'b1;  // Mux, then convert, then reads
                    end else begin
                        board <= board + 1'b1;
                    end
                    state <= phase_bus_pkg::SEQ_ADDRESS;
                end

                phase_bus_pkg::SEQ_FINISH: begin
                    state <= phase_bus_pkg::SEQ_IDLE;
                end

                default: begin
                    state <= phase_bus_pkg::SEQ_IDLE;
                end
            endcase
        end
    end

    // Write data, only meaningful while data_dir is high
    always_ff @(posedge clock) begin
        if (state == phase_bus_pkg::SEQ_ADDRESS) begin
            data_out <= access_data;
        end
    end

    // Read byte is taken on the last strobe cycle while rd_n is still low
    assign sample      = (state == phase_bus_pkg::SEQ_STROBE) && strobe_end && !is_write;
    assign sample_slot = board;
    assign finish      = (state == phase_bus_pkg::SEQ_FINISH);  // One cycle after last release

endmodule

/* hw/command_capture.sv */
module command_capture (
    input  logic                 clock,
    input  logic                 reset,

    // Host side
    input  logic                 start,
    input  phase_bus_pkg::cmd_t  command,
    input  phase_bus_pkg::byte_t param_data [phase_bus_pkg::NUM_BOARDS],
    output logic                 busy,

    // To the sequencer
    output logic                 go,
    output phase_bus_pkg::cmd_t  cmd,
    output phase_bus_pkg::byte_t params [phase_bus_pkg::NUM_BOARDS],
    input  logic                 finish
);

    logic accept;  // Start qualified by idle

    // Anything that shows up while a run is going on is simply lost
    assign accept = start && !busy;

    // Busy and go
    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= 1'b0;
            go   <= 1'b0;
        end else begin
            go <= accept;  // One cycle pulse, rises with busy
            if (accept) begin
                busy <= 1'b1;
            end else if (finish) begin
                busy <= 1'b0;  // Low the cycle after finish
            end
        end
    end

    // Command and parameters held for the whole run
    // so the host may move on as soon as start is taken
    always_ff @(posedge clock) begin
        if (accept) begin
            cmd    <= command;
            params <= param_data;
        end
    end

endmodule

/* common/phase_bus_pkg.sv */
package phase_bus_pkg;

    // Bus and response widths
    typedef logic [7:0] byte_t;   // One phase bus data byte
    typedef logic [3:0] board_t;  // Board select code on the bus
    typedef logic [2:0] port_t;   // Port address on a card
    typedef logic [1:0] slot_t;   // Board or response slot index
    typedef logic [2:0] count_t;  // Response byte count, 0 to 4

    // Host command codes
    typedef enum logic [1:0] {
        CMD_WRITE4,  // Parameter byte i to board i
        CMD_READ4,   // One lamp byte from each board
        CMD_ADC4     // Mux write, convert write, four ADC reads
    } cmd_t;

    // Sequencer states, one bus access walks ADDRESS to RELEASE
    typedef enum logic [3:0] {
        SEQ_IDLE,
        SEQ_ADDRESS,  // Present board, port and direction
        SEQ_SETTLE,   // Let the card decode the address
        SEQ_STROBE,   // rd_n or wr_n held low
        SEQ_RELEASE,  // Strobe back high, address still held
        SEQ_NEXT,     // Step to the next board or adc4 pass
        SEQ_FINISH
    } seq_state_t;

    localparam int NUM_BOARDS = 4;

    // Select codes, board i answers to code i
    localparam board_t BOARD_NONE = 4'hF;  // Nobody selected
    localparam board_t BOARD_ALL  = 4'd5;  // Broadcast to every card

    // Card ports
    localparam port_t PORT_LAMP = 3'd0;  // Lamp switch register
    localparam port_t PORT_MUX  = 3'd3;  // Analog mux latch
    localparam port_t PORT_ADC  = 3'd5;  // ADC result

    // Bus timing in clock cycles
    localparam int SETTLE_CYCLES = 21;  // After an address change and after a release
    localparam int STROBE_CYCLES = 2;   // Strobe low time

    // Shared wait counter, sized for the longer of the two waits
    typedef logic [$clog2(SETTLE_CYCLES)-1:0] wait_t;

endpackage
